// ==== source/pd_sink_defines.svh ====
// ====================================================================
// USB PD sink shared constants: message codes, widths, timer limits
// ====================================================================
`ifndef PD_SINK_DEFINES_SVH
`define PD_SINK_DEFINES_SVH

// Header field widths
`define PD_TYPE_W         5
`define PD_NUM_W          3
`define PD_ID_W           3
`define PD_OBJ_W          32
`define PD_MAX_OBJS       7

// Control messages carry zero objects
`define PD_CTRL_GOODCRC   5'd1
`define PD_CTRL_ACCEPT    5'd3
`define PD_CTRL_PS_RDY    5'd6

// Data messages carry one or more objects
`define PD_DATA_SRC_CAP   5'd1
`define PD_DATA_REQUEST   5'd2

// Timer limits in clock cycles, scaled down for simulation
`define PD_TIMER_W        9
`define PD_GAP_CYCLES     8
`define PD_RESP_TIMEOUT   200
`define PD_READY_TIMEOUT  400

`define PD_CREDIT_W       2
`define PD_CREDIT_MAX     2

// 9 V in 50 mV units
`define PD_TARGET_MV50    180

`endif

// ==== source/pd_sink_pkg.sv ====
// ====================================================================
// USB PD sink types: data object views and policy states
// ====================================================================
package pd_sink_pkg;

	// Fixed supply PDO as sent by the source
	typedef struct packed {
		logic [1:0] supply;
		logic [9:0] flags;
		logic [9:0] volt_mv50;
		logic [9:0] max_ma10;
	} pd_fixed_pdo_t;

	// Fixed supply request object
	typedef struct packed {
		logic       rsvd;
		logic [2:0] obj_pos;
		logic       give_back;
		logic       cap_mismatch;
		logic [5:0] flags;
		logic [9:0] op_ma10;
		logic [9:0] max_ma10;
	} pd_fixed_rdo_t;

	typedef union packed {
		pd_fixed_pdo_t pdo;
		pd_fixed_rdo_t rdo;
	} pd_data_obj_u;

	typedef enum logic [3:0] {
		wait_caps,
		ack_caps,
		build_req,
		send_req,
		wait_crc,
		wait_accept,
		wait_ready,
		ack_ready,
		contract,
		fail,
		idle
	} pd_policy_state_e;

endpackage

// ==== source/pd_sink_policy.sv ====
// ====================================================================
// USB PD sink policy FSM: capabilities, request, accept, PS_RDY
// ====================================================================
`timescale 1ns/1ns
`include "pd_sink_defines.svh"

module pd_sink_policy import pd_sink_pkg::*; (
	input  logic                  glb_clk,
	input  logic                  glb_nrst,

	input  logic                  rx_hdr_valid,
	input  logic                  rx_crc_ok,
	input  logic [`PD_TYPE_W-1:0] rx_type,
	input  logic [`PD_NUM_W-1:0]  rx_num,
	input  logic [`PD_ID_W-1:0]   rx_id,
	input  logic                  rx_obj_valid,

	input  logic                  detach,
	input  logic                  msg_pending,
	input  logic                  req_found,
	input  logic [`PD_NUM_W-1:0]  req_pos,

	output logic                  cap_clear,
	output logic                  cap_capture,

	output logic                  msg_load,
	output logic [`PD_TYPE_W-1:0] msg_type,
	output logic [`PD_NUM_W-1:0]  msg_num,
	output logic [`PD_ID_W-1:0]   msg_id,

	output logic                  contract_ok,
	output logic                  contract_err,
	output logic [2:0]            contract_pos
);

	pd_policy_state_e        state;
	pd_policy_state_e        state_nxt;
	logic [`PD_TIMER_W-1:0]  timer;
	logic                    loaded;
	logic                    cap_rx;
	logic [`PD_NUM_W-1:0]    obj_left;
	logic [`PD_ID_W-1:0]     last_id;
	logic [`PD_ID_W-1:0]     req_id;

	logic hdr_good;
	logic caps_hit;
	logic caps_end;
	logic crc_hit;
	logic accept_hit;
	logic ready_hit;
	logic tx_done;
	logic reply_go;

	// ================================================================
	// Header filters
	// ================================================================
	assign hdr_good   = rx_hdr_valid && rx_crc_ok;
	assign caps_hit   = hdr_good && (state == wait_caps) && !cap_rx &&
		(rx_type == `PD_DATA_SRC_CAP) && (rx_num != '0);
	assign caps_end   = cap_rx && rx_obj_valid && (obj_left == `PD_NUM_W'(1));
	assign crc_hit    = hdr_good && (state == wait_crc) &&
		(rx_type == `PD_CTRL_GOODCRC) && (rx_num == '0);
	assign accept_hit = hdr_good && (state == wait_accept) &&
		(rx_type == `PD_CTRL_ACCEPT) && (rx_num == '0);

	// PS_RDY only counts once our GoodCRC for Accept is out
	assign ready_hit  = hdr_good && (state == wait_ready) && tx_done &&
		(rx_type == `PD_CTRL_PS_RDY) && (rx_num == '0);

	// Gate has taken and released our message
	assign tx_done  = loaded && !msg_pending;
	assign reply_go = !loaded && !msg_pending && (timer >= `PD_GAP_CYCLES);

	assign cap_clear   = caps_hit;
	assign cap_capture = cap_rx;

	always_comb begin
		case (state)
			ack_caps, wait_ready, ack_ready: msg_load = reply_go;
			send_req:                        msg_load = !loaded && !msg_pending;
			default:                         msg_load = 1'b0;
		endcase
	end

	assign msg_type = (state == send_req) ? `PD_DATA_REQUEST : `PD_CTRL_GOODCRC;
	assign msg_num  = (state == send_req) ? `PD_NUM_W'(1) : '0;
	assign msg_id   = (state == send_req) ? req_id : last_id;

	// ================================================================
	// Next state
	// ================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			wait_caps:   if (caps_end) state_nxt = ack_caps;
			ack_caps:    if (tx_done) state_nxt = build_req;
			build_req: begin
				// Select result settles one cycle in
				if (timer != '0)
					state_nxt = req_found ? send_req : fail;
			end
			send_req:    if (tx_done) state_nxt = wait_crc;
			wait_crc: begin
				if (crc_hit)
					state_nxt = wait_accept;
				else if (timer == `PD_RESP_TIMEOUT - 1)
					state_nxt = idle;
			end
			wait_accept: begin
				if (accept_hit)
					state_nxt = wait_ready;
				else if (timer == `PD_RESP_TIMEOUT - 1)
					state_nxt = idle;
			end
			wait_ready: begin
				if (ready_hit)
					state_nxt = ack_ready;
				else if (timer == `PD_READY_TIMEOUT - 1)
					state_nxt = idle;
			end
			ack_ready:   if (tx_done) state_nxt = contract;
			contract, fail, idle: begin
				if (detach)
					state_nxt = wait_caps;
			end
			default:     state_nxt = idle;
		endcase
	end

	always_ff @(posedge glb_clk) begin
		if (!glb_nrst) begin
			state        <= wait_caps;
			timer        <= '0;
			loaded       <= 1'b0;
			cap_rx       <= 1'b0;
			obj_left     <= '0;
			req_id       <= '0;
			contract_ok  <= 1'b0;
			contract_err <= 1'b0;
			contract_pos <= '0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state) begin
				timer  <= '0;
				loaded <= 1'b0;
			end else begin
				if (timer != '1)
					timer <= timer + 1'b1;
				if (msg_load)
					loaded <= 1'b1;
			end

			// Object count of the capabilities message in flight
			if (caps_hit) begin
				cap_rx   <= 1'b1;
				obj_left <= rx_num;
			end else if (caps_end) begin
				cap_rx <= 1'b0;
			end else if (cap_rx && rx_obj_valid) begin
				obj_left <= obj_left - 1'b1;
			end

			if (msg_load && state == send_req)
				req_id <= req_id + 1'b1;

			contract_ok  <= (state_nxt == contract);
			contract_err <= (state_nxt == fail);
			if (state == build_req && state_nxt == send_req)
				contract_pos <= req_pos;
			else if (state_nxt == wait_caps)
				contract_pos <= '0;
		end
	end

	// Id echoed back in our GoodCRC
	always_ff @(posedge glb_clk) begin
		if (caps_hit || accept_hit || ready_hit)
			last_id <= rx_id;
	end

endmodule

// ==== source/pd_pdo_select.sv ====
// ====================================================================
// Source capability store and fixed-supply request builder
// ====================================================================
`timescale 1ns/1ns
`include "pd_sink_defines.svh"

module pd_pdo_select import pd_sink_pkg::*; #(
	parameter logic [9:0] target_mv50 = `PD_TARGET_MV50
)(
	input  logic                 glb_clk,
	input  logic                 glb_nrst,
	input  logic                 cap_clear,
	input  logic                 cap_capture,
	input  logic                 rx_obj_valid,
	input  pd_data_obj_u         rx_obj,
	output logic                 req_found,
	output logic [`PD_NUM_W-1:0] req_pos,
	output pd_data_obj_u         req_word
);

	pd_data_obj_u          cap_mem [0:`PD_MAX_OBJS-1];
	logic [`PD_NUM_W-1:0]  cap_cnt;
	logic                  hit;
	logic [`PD_NUM_W-1:0]  hit_idx;
	pd_data_obj_u          rdo_nxt;

	always_ff @(posedge glb_clk) begin
		if (!glb_nrst) begin
			cap_cnt <= '0;
		end else if (cap_clear) begin
			cap_cnt <= '0;
		end else if (cap_capture && rx_obj_valid && cap_cnt < `PD_MAX_OBJS) begin
			cap_cnt <= cap_cnt + 1'b1;
		end
	end

	always_ff @(posedge glb_clk) begin
		if (cap_capture && rx_obj_valid && cap_cnt < `PD_MAX_OBJS)
			cap_mem[cap_cnt] <= rx_obj;
	end

	// First fixed supply at the target voltage wins
	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < `PD_MAX_OBJS; i++) begin
			if (!hit && i < cap_cnt && cap_mem[i].pdo.supply == 2'b00 &&
				cap_mem[i].pdo.volt_mv50 == target_mv50) begin
				hit     = 1'b1;
				hit_idx = `PD_NUM_W'(i);
			end
		end
	end

	always_comb begin
		rdo_nxt              = '0;
		rdo_nxt.rdo.obj_pos  = hit_idx + 1'b1;
		rdo_nxt.rdo.op_ma10  = cap_mem[hit_idx].pdo.max_ma10;
		rdo_nxt.rdo.max_ma10 = cap_mem[hit_idx].pdo.max_ma10;
	end

	always_ff @(posedge glb_clk) begin
		if (!glb_nrst)
			req_found <= 1'b0;
		else
			req_found <= hit;
	end

	always_ff @(posedge glb_clk) begin
		req_pos  <= hit_idx + 1'b1;
		req_word <= rdo_nxt;
	end

endmodule

// ==== source/pd_tx_credit.sv ====
// ====================================================================
// Transmit gate, one held message released against PHY credits
// ====================================================================
`timescale 1ns/1ns
`include "pd_sink_defines.svh"

module pd_tx_credit import pd_sink_pkg::*; (
	input  logic                  glb_clk,
	input  logic                  glb_nrst,
	input  logic                  tx_credit,
	input  logic                  msg_load,
	input  logic [`PD_TYPE_W-1:0] msg_type,
	input  logic [`PD_NUM_W-1:0]  msg_num,
	input  logic [`PD_ID_W-1:0]   msg_id,
	input  pd_data_obj_u          msg_obj,
	output logic                  msg_pending,
	output logic                  tx_valid,
	output logic [`PD_TYPE_W-1:0] tx_type,
	output logic [`PD_NUM_W-1:0]  tx_num,
	output logic [`PD_ID_W-1:0]   tx_id,
	output logic [`PD_OBJ_W-1:0]  tx_obj
);

	logic [`PD_CREDIT_W-1:0] credit_cnt;
	logic                    credit_avail;
	logic                    send;

	// A credit arriving this cycle can be spent right away
	assign credit_avail = (credit_cnt != '0) || tx_credit;
	assign send         = (msg_load || msg_pending) && credit_avail;

	always_ff @(posedge glb_clk) begin
		if (!glb_nrst) begin
			credit_cnt  <= '0;
			msg_pending <= 1'b0;
			tx_valid    <= 1'b0;
		end else begin
			tx_valid <= send;
			if (msg_load)
				msg_pending <= !credit_avail;
			else if (send)
				msg_pending <= 1'b0;

			// Return and spend in one cycle cancel out
			if (tx_credit && !send && credit_cnt != `PD_CREDIT_MAX)
				credit_cnt <= credit_cnt + 1'b1;
			else if (send && !tx_credit)
				credit_cnt <= credit_cnt - 1'b1;
		end
	end

	// Output fields double as the holding register
	always_ff @(posedge glb_clk) begin
		if (msg_load) begin
			tx_type <= msg_type;
			tx_num  <= msg_num;
			tx_id   <= msg_id;
			tx_obj  <= msg_obj;
		end
	end

endmodule

// ==== source/pd_sink_top.sv ====
// ====================================================================
// USB PD sink top: policy engine, capability store, transmit gate
// ====================================================================
`timescale 1ns/1ns
`include "pd_sink_defines.svh"

module pd_sink_top import pd_sink_pkg::*; #(
	parameter logic [9:0] target_mv50 = `PD_TARGET_MV50
)(
	input  logic                  glb_clk,
	input  logic                  glb_nrst,

	input  logic                  rx_hdr_valid,
	input  logic                  rx_crc_ok,
	input  logic [`PD_TYPE_W-1:0] rx_type,
	input  logic [`PD_NUM_W-1:0]  rx_num,
	input  logic [`PD_ID_W-1:0]   rx_id,
	input  logic                  rx_obj_valid,
	input  logic [`PD_OBJ_W-1:0]  rx_obj,

	input  logic                  tx_credit,
	input  logic                  detach,

	output logic                  tx_valid,
	output logic [`PD_TYPE_W-1:0] tx_type,
	output logic [`PD_NUM_W-1:0]  tx_num,
	output logic [`PD_ID_W-1:0]   tx_id,
	output logic [`PD_OBJ_W-1:0]  tx_obj,

	output logic                  contract_ok,
	output logic                  contract_err,
	output logic [2:0]            contract_pos
);

	logic                  cap_clear;
	logic                  cap_capture;
	logic                  req_found;
	logic [`PD_NUM_W-1:0]  req_pos;
	pd_data_obj_u          req_word;

	logic                  msg_load;
	logic [`PD_TYPE_W-1:0] msg_type;
	logic [`PD_NUM_W-1:0]  msg_num;
	logic [`PD_ID_W-1:0]   msg_id;
	logic                  msg_pending;

	pd_sink_policy u_policy (
		.glb_clk      (glb_clk),
		.glb_nrst     (glb_nrst),
		.rx_hdr_valid (rx_hdr_valid),
		.rx_crc_ok    (rx_crc_ok),
		.rx_type      (rx_type),
		.rx_num       (rx_num),
		.rx_id        (rx_id),
		.rx_obj_valid (rx_obj_valid),
		.detach       (detach),
		.msg_pending  (msg_pending),
		.req_found    (req_found),
		.req_pos      (req_pos),
		.cap_clear    (cap_clear),
		.cap_capture  (cap_capture),
		.msg_load     (msg_load),
		.msg_type     (msg_type),
		.msg_num      (msg_num),
		.msg_id       (msg_id),
		.contract_ok  (contract_ok),
		.contract_err (contract_err),
		.contract_pos (contract_pos)
	);

	pd_pdo_select #(
		.target_mv50 (target_mv50)
	) u_pdo_select (
		.glb_clk      (glb_clk),
		.glb_nrst     (glb_nrst),
		.cap_clear    (cap_clear),
		.cap_capture  (cap_capture),
		.rx_obj_valid (rx_obj_valid),
		.rx_obj       (rx_obj),
		.req_found    (req_found),
		.req_pos      (req_pos),
		.req_word     (req_word)
	);

	pd_tx_credit u_tx_credit (
		.glb_clk     (glb_clk),
		.glb_nrst    (glb_nrst),
		.tx_credit   (tx_credit),
		.msg_load    (msg_load),
		.msg_type    (msg_type),
		.msg_num     (msg_num),
		.msg_id      (msg_id),
		.msg_obj     (req_word),
		.msg_pending (msg_pending),
		.tx_valid    (tx_valid),
		.tx_type     (tx_type),
		.tx_num      (tx_num),
		.tx_id       (tx_id),
		.tx_obj      (tx_obj)
	);

endmodule

// ==== dv/pd_sink_checker.sv ====
// ====================================================================
// Checker for the USB PD sink transmit order, ids and contract
// ====================================================================
`timescale 1ns/1ns
`include "pd_sink_defines.svh"

module pd_sink_checker (
	input  logic                  glb_clk,
	input  logic                  glb_nrst,
	input  logic                  rx_hdr_valid,
	input  logic                  rx_crc_ok,
	input  logic [`PD_TYPE_W-1:0] rx_type,
	input  logic [`PD_NUM_W-1:0]  rx_num,
	input  logic [`PD_ID_W-1:0]   rx_id,
	input  logic                  tx_credit,
	input  logic                  tx_valid,
	input  logic [`PD_TYPE_W-1:0] tx_type,
	input  logic [`PD_NUM_W-1:0]  tx_num,
	input  logic [`PD_ID_W-1:0]   tx_id,
	input  logic [`PD_OBJ_W-1:0]  tx_obj,
	input  logic                  contract_ok,
	input  logic                  contract_err,
	input  logic [2:0]            contract_pos,
	input  logic                  rec_start,
	input  logic                  rec_done,
	input  logic [1:0]            exp_outcome,
	input  logic [2:0]            exp_pos,
	input  logic [31:0]           exp_word,
	output int                    err_cnt
);

	int                 gcrc_cnt;
	int                 req_cnt;
	int                 credit_cnt;
	logic               credit_q;
	logic [`PD_ID_W-1:0] echo_id;
	logic [`PD_ID_W-1:0] req_id_exp;

	task automatic report_err(input string msg);
		err_cnt = err_cnt + 1;
		$display("ERR %0t: %s", $time, msg);
	endtask

	always @(posedge glb_clk) begin
		if (!glb_nrst) begin
			err_cnt    = 0;
			credit_cnt = 0;
			credit_q   = 1'b0;
			req_id_exp = '0;
			gcrc_cnt   = 0;
			req_cnt    = 0;
		end else begin
			// A send uses a stored credit or one arriving that cycle
			if (tx_valid && credit_cnt == 0 && !credit_q)
				report_err("tx_valid while no credit was available");
			if (credit_q && !tx_valid && credit_cnt != `PD_CREDIT_MAX)
				credit_cnt = credit_cnt + 1;
			else if (tx_valid && !credit_q)
				credit_cnt = credit_cnt - 1;
			credit_q = tx_credit;

			if (rec_start) begin
				gcrc_cnt = 0;
				req_cnt  = 0;
			end

			// Ids that a GoodCRC has to echo
			if (rx_hdr_valid && rx_crc_ok &&
				((rx_type == `PD_DATA_SRC_CAP && rx_num != '0) ||
				 (rx_type == `PD_CTRL_ACCEPT && rx_num == '0) ||
				 (rx_type == `PD_CTRL_PS_RDY && rx_num == '0)))
				echo_id = rx_id;

			if (tx_valid) begin
				if (tx_type == `PD_CTRL_GOODCRC && tx_num == '0) begin
					gcrc_cnt = gcrc_cnt + 1;
					if (tx_id != echo_id)
						report_err($sformatf("GoodCRC id %0d, expected %0d", tx_id, echo_id));
				end else if (tx_type == `PD_DATA_REQUEST && tx_num == `PD_NUM_W'(1)) begin
					req_cnt = req_cnt + 1;
					if (gcrc_cnt != 1)
						report_err("Request sent before the capabilities GoodCRC");
					if (tx_obj != exp_word)
						report_err($sformatf("Request word %h, expected %h", tx_obj, exp_word));
					if (tx_id != req_id_exp)
						report_err($sformatf("Request id %0d, expected %0d", tx_id, req_id_exp));
					req_id_exp = req_id_exp + 1'b1;
				end else begin
					report_err($sformatf("unexpected message type %0d num %0d", tx_type, tx_num));
				end
			end

			// Contract only after the GoodCRC for PS_RDY has gone out
			if (contract_ok && gcrc_cnt < 3)
				report_err("contract_ok high before the GoodCRC for PS_RDY");

			if (rec_done) begin
				if (gcrc_cnt != ((exp_outcome == 2'd0) ? 3 : 1))
					report_err($sformatf("%0d GoodCRC messages in record", gcrc_cnt));
				if (req_cnt != ((exp_outcome == 2'd1) ? 0 : 1))
					report_err($sformatf("%0d Request messages in record", req_cnt));
				if (contract_ok != (exp_outcome == 2'd0))
					report_err($sformatf("contract_ok is %b", contract_ok));
				if (contract_err != (exp_outcome == 2'd1))
					report_err($sformatf("contract_err is %b", contract_err));
				if (exp_outcome == 2'd0 && contract_pos != exp_pos)
					report_err($sformatf("contract_pos %0d, expected %0d", contract_pos, exp_pos));
			end
		end
	end

endmodule

// ==== dv/pd_sink_tb.sv ====
// ====================================================================
// USB PD sink testbench with a source stand-in driven from a record file
// ====================================================================
`timescale 1ns/1ns
`include "pd_sink_defines.svh"

module pd_sink_tb;

	logic glb_clk = 1'b0;
	logic glb_nrst, rx_hdr_valid, rx_crc_ok, rx_obj_valid, detach;
	logic tx_credit = 1'b0;
	logic [`PD_TYPE_W-1:0] rx_type, tx_type;
	logic [`PD_NUM_W-1:0]  rx_num, tx_num;
	logic [`PD_ID_W-1:0]   rx_id, tx_id, src_id;
	logic [`PD_OBJ_W-1:0]  rx_obj, tx_obj;
	logic tx_valid, contract_ok, contract_err;
	logic [2:0] contract_pos;
	logic rec_start, rec_done, slow_credit;
	logic [1:0]  exp_outcome;
	logic [2:0]  exp_pos;
	logic [31:0] exp_word;
	logic [31:0] rec_obj [0:15][0:6];
	logic [31:0] rec_num [0:15], rec_bad [0:15], rec_acc [0:15], rec_slow [0:15];
	logic [31:0] rec_pos [0:15], rec_out [0:15], rec_word [0:15];
	reg [8*200-1:0] line;
	integer seed = 54209;
	int chk_errs, tb_errs, nrec, fd, credit_timer, ok;
	int cycles = 0;
	int cycle_limit = 32'h7fff_ffff;

	always #10 glb_clk = ~glb_clk;

	pd_sink_top uut (.*);

	pd_sink_checker u_checker (.*, .err_cnt(chk_errs));

	// PHY hands back one credit some time after each message
	always @(posedge glb_clk) begin
		if (!glb_nrst) begin
			tx_credit    <= 1'b0;
			credit_timer <= 3;
		end else begin
			tx_credit <= 1'b0;
			if (tx_valid)
				credit_timer <= slow_credit ? 4 + $unsigned($random(seed)) % 30 : 1;
			else if (credit_timer == 1) begin
				tx_credit    <= 1'b1;
				credit_timer <= 0;
			end else if (credit_timer != 0)
				credit_timer <= credit_timer - 1;
		end
	end

	always @(posedge glb_clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Run stopped: cycle limit of %0d reached", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic send_hdr(input [4:0] typ, input [2:0] num, input [2:0] id, input crc);
		@(posedge glb_clk);
		rx_hdr_valid <= 1'b1;
		rx_type      <= typ;
		rx_num       <= num;
		rx_id        <= id;
		rx_crc_ok    <= crc;
		@(posedge glb_clk);
		rx_hdr_valid <= 1'b0;
	endtask

	task automatic send_obj(input [31:0] word);
		@(posedge glb_clk);
		rx_obj_valid <= 1'b1;
		rx_obj       <= word;
		@(posedge glb_clk);
		rx_obj_valid <= 1'b0;
	endtask

	// DUT outputs are sampled on the falling edge
	task automatic wait_tx(input string what);
		int n;
		n = 0;
		do begin
			@(negedge glb_clk);
			n++;
		end while (!tx_valid && n < 1000);
		if (!tx_valid) begin
			tb_errs++;
			$display("No %s message came from the DUT", what);
		end
	endtask

	task automatic wait_flag(input int sel);
		int n;
		n = 0;
		do begin
			@(negedge glb_clk);
			n++;
		end while (!(sel ? contract_err : contract_ok) && n < 1000);
		if (!(sel ? contract_err : contract_ok)) begin
			tb_errs++;
			$display("Contract output %0d never went high", sel);
		end
	endtask

	initial begin
		{glb_nrst, rx_hdr_valid, rx_crc_ok, rx_obj_valid, detach} = '0;
		{rx_type, rx_num, rx_id, rx_obj, src_id} = '0;
		{rec_start, rec_done, slow_credit, exp_outcome, exp_pos, exp_word} = '0;
		tb_errs = 0;
		nrec    = 0;
		fd = $fopen("dv/pd_sink_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file");
			$display("Simulation failed");
			$finish;
		end else begin
			while (!$feof(fd) && nrec < 16) begin
				line = '0;
				ok = $fgets(line, fd);
				ok = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					rec_num[nrec], rec_obj[nrec][0], rec_obj[nrec][1], rec_obj[nrec][2],
					rec_obj[nrec][3], rec_obj[nrec][4], rec_obj[nrec][5], rec_obj[nrec][6],
					rec_bad[nrec], rec_acc[nrec], rec_slow[nrec], rec_pos[nrec],
					rec_out[nrec], rec_word[nrec]);
				if (ok == 14)
					nrec++;
			end
			$fclose(fd);
			cycle_limit = nrec * (`PD_READY_TIMEOUT + 2000) + 100;

			repeat (16) @(posedge glb_clk);
			glb_nrst <= 1'b1;
			repeat (10) @(posedge glb_clk);

			for (int r = 0; r < nrec; r++) begin
				@(posedge glb_clk);
				exp_outcome <= rec_out[r][1:0];
				exp_pos     <= rec_pos[r][2:0];
				exp_word    <= rec_word[r];
				slow_credit <= rec_slow[r][0];
				@(posedge glb_clk);
				rec_start <= 1'b1;
				@(posedge glb_clk);
				rec_start <= 1'b0;
				if (rec_bad[r][0]) begin
					send_hdr(`PD_DATA_SRC_CAP, 3'd1, src_id, 1'b0);
					send_obj(32'h0001912C);
				end
				send_hdr(`PD_DATA_SRC_CAP, rec_num[r][2:0], src_id, 1'b1);
				src_id++;
				for (int i = 0; i < rec_num[r]; i++)
					send_obj(rec_obj[r][i]);
				wait_tx("GoodCRC for capabilities");
				if (rec_out[r] == 1) begin
					wait_flag(1);
				end else begin
					wait_tx("Request");
					send_hdr(`PD_CTRL_GOODCRC, 3'd0, 3'd0, 1'b1);
					if (rec_acc[r][0]) begin
						send_hdr(`PD_CTRL_ACCEPT, 3'd0, src_id, 1'b1);
						src_id++;
						wait_tx("GoodCRC for Accept");
						send_hdr(`PD_CTRL_PS_RDY, 3'd0, src_id, 1'b1);
						src_id++;
						wait_tx("GoodCRC for PS_RDY");
						wait_flag(0);
					end else begin
						repeat (`PD_RESP_TIMEOUT + 20) @(posedge glb_clk);
					end
				end
				@(negedge glb_clk);
				@(posedge glb_clk);
				rec_done <= 1'b1;
				@(posedge glb_clk);
				rec_done <= 1'b0;
				@(posedge glb_clk);
				detach <= 1'b1;
				@(posedge glb_clk);
				detach <= 1'b0;
				repeat (5) @(posedge glb_clk);
			end

			repeat (5) @(posedge glb_clk);
			$display("Errors: checker %0d, testbench %0d", chk_errs, tb_errs);
			if (chk_errs == 0 && tb_errs == 0 && nrec > 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== pd_sink_top.f ====
+incdir+source
source/pd_sink_pkg.sv
source/pd_sink_policy.sv
source/pd_pdo_select.sv
source/pd_tx_credit.sv
source/pd_sink_top.sv
dv/pd_sink_checker.sv
dv/pd_sink_tb.sv

// ==== dv/pd_sink_testdata.txt ====
# num obj0 obj1 obj2 obj3 obj4 obj5 obj6 bad_crc accept slow_credit exp_pos outcome exp_word
# outcome 0 contract, 1 no matching object, 2 no Accept from source
# Match at the first object
3 0002D0C8 0001912C 0004B12C 00000000 00000000 00000000 00000000 0 1 0 1 0 100320C8
# Match in the middle, credits held back
4 0001912C 0002D12C 0004B12C 0002D0C8 00000000 00000000 00000000 0 1 1 2 0 2004B12C
# Match at the last object, a non-fixed 9 V object is skipped
7 0001912C C002D12C 0003C096 0004B12C 000640E1 0001912C 0002D12C 0 1 0 7 0 7004B12C
# No 9 V object
3 0001912C 0003C096 0004B12C 00000000 00000000 00000000 00000000 0 1 0 0 1 00000000
# Source never sends Accept
2 0001912C 0002D12C 00000000 00000000 00000000 00000000 00000000 0 0 0 2 2 2004B12C
# Bad CRC header first, then a normal negotiation
2 0002D12C 0001912C 00000000 00000000 00000000 00000000 00000000 1 1 1 1 0 1004B12C
# Single object, credits held back
1 0002D0C8 00000000 00000000 00000000 00000000 00000000 00000000 0 1 1 1 0 100320C8
